// ==== logic/rv32_settings.svh ====
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// data path width.
`define RV32_XLEN 32

// memory depth in words, byte address bits 11:2.
`define RV32_MEM_WORDS 1024

`define RV32_RESET_PC 32'h0000_0000

`endif

// ==== logic/rv32_isa_pkg.sv ====
`include "rv32_settings.svh"

package rv32_isa_pkg;

   typedef enum logic [6:0] {
      OP_LUI    = 7'b0110111,
      OP_AUIPC  = 7'b0010111,
      OP_JAL    = 7'b1101111,
      OP_JALR   = 7'b1100111,
      OP_BRANCH = 7'b1100011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011,
      OP_FENCE  = 7'b0001111,
      OP_SYSTEM = 7'b1110011
   } opcode_e;

   // branch conditions, from funct3.
   typedef enum logic [2:0] {
      F3_BEQ  = 3'b000,
      F3_BNE  = 3'b001,
      F3_BLT  = 3'b100,
      F3_BGE  = 3'b101,
      F3_BLTU = 3'b110,
      F3_BGEU = 3'b111
   } branch_f3_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND
   } alu_op_e;

   typedef struct packed {
      opcode_e                opcode;
      logic [4:0]             rd;
      logic [4:0]             rs1;
      logic [4:0]             rs2;
      logic [2:0]             funct3;
      alu_op_e                alu_op;
      logic [`RV32_XLEN-1:0]  imm;
      logic                   writes_rd;
      logic                   is_illegal;
   } decoded_t;

endpackage

// ==== logic/rv32_core_pkg.sv ====
`include "rv32_settings.svh"

package rv32_core_pkg;

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_EXEC,
      S_LOAD,
      S_HALT
   } seq_state_e;

   // memory write port and core store bus.
   typedef struct packed {
      logic                   valid;
      logic [`RV32_XLEN-1:0]  address;
      logic [`RV32_XLEN-1:0]  value;
   } store_t;

   typedef struct packed {
      logic                   take;
      logic [`RV32_XLEN-1:0]  target;
   } pc_update_t;

endpackage

// ==== logic/memory.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module memory
   import rv32_core_pkg::*;
(
   input  logic        clock,
   input  logic        read_enable,
   input  logic [31:0] read_address,
   output logic [31:0] read_value,
   input  store_t      write
);

   logic [31:0] words [0:`RV32_MEM_WORDS-1];

   always_ff @(posedge clock) begin
      if (write.valid) begin
         words[write.address[11:2]] <= write.value;
      end
   end

   // one cycle read latency.
   always_ff @(posedge clock) begin
      if (read_enable) begin
         read_value <= words[read_address[11:2]];
      end
   end

endmodule

// ==== logic/program_counter.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module program_counter
   import rv32_core_pkg::*;
(
   input  logic        clock,
   input  logic        rst_n,
   input  logic        retire,
   input  pc_update_t  update,
   output logic [31:0] pc
);

   logic [31:0] pc_next;

   assign pc_next = update.take ? update.target : pc + 32'd4;

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         pc <= `RV32_RESET_PC;
      end else if (retire) begin
         pc <= pc_next; // only moves once per instruction.
      end
   end

endmodule

// ==== logic/fetch.sv ====
`timescale 1ns/100ps

module fetch
   import rv32_core_pkg::*;
(
   input  logic        clock,
   input  logic        rst_n,
   input  logic        run,
   input  logic [31:0] pc,
   input  logic        load_request,
   input  logic [31:0] load_address,
   input  logic        halt_request,
   output logic        read_enable,
   output logic [31:0] read_address,
   input  logic [31:0] read_value,
   output logic [31:0] instruction,
   output logic [31:0] instruction_pc,
   output logic        exec,
   output logic        load_done,
   output logic        retire,
   output logic        halted
);

   seq_state_e  state;
   seq_state_e  state_next;
   logic [31:0] ir;

   always_comb begin
      state_next = state;
      case (state)
         S_IDLE:  if (run) state_next = S_FETCH;
         S_FETCH: state_next = S_EXEC;
         S_EXEC: begin
            if (halt_request) state_next = S_HALT;
            else if (load_request) state_next = S_LOAD;
            else state_next = S_FETCH;
         end
         S_LOAD:  state_next = S_FETCH;
         S_HALT:  state_next = S_HALT; // left only by reset.
         default: state_next = S_IDLE;
      endcase
   end

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         state <= S_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // instruction word is held across the load cycle.
   always_ff @(posedge clock) begin
      if (state == S_FETCH) instruction_pc <= pc;
      if (exec) ir <= read_value;
   end

   assign exec      = (state == S_EXEC);
   assign load_done = (state == S_LOAD);
   assign halted    = (state == S_HALT);
   assign retire    = (exec && !load_request && !halt_request) || load_done;

   // load address wins during the exec cycle of LW.
   assign read_enable  = (state == S_FETCH) || load_request;
   assign read_address = load_request ? load_address : pc;
   assign instruction  = load_done ? ir : read_value;

endmodule

// ==== logic/decode.sv ====
`timescale 1ns/100ps

module decode
   import rv32_isa_pkg::*;
(
   input  logic [31:0] instruction,
   output decoded_t    decoded
);

   logic [31:0] imm_i;
   logic [31:0] imm_s;
   logic [31:0] imm_b;
   logic [31:0] imm_u;
   logic [31:0] imm_j;
   logic        alt; // funct7 bit 5, sub and sra.

   assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
   assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
   assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
   assign imm_u = {instruction[31:12], 12'd0};
   assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};
   assign alt   = instruction[30];

   always_comb begin
      decoded.opcode     = opcode_e'(instruction[6:0]);
      decoded.rd         = instruction[11:7];
      decoded.funct3     = instruction[14:12];
      decoded.rs1        = instruction[19:15];
      decoded.rs2        = instruction[24:20];
      decoded.alu_op     = ALU_ADD;
      decoded.imm        = imm_i;
      decoded.writes_rd  = 1'b0;
      decoded.is_illegal = 1'b0;
      case (opcode_e'(instruction[6:0]))
         OP_LUI, OP_AUIPC: begin
            decoded.imm       = imm_u;
            decoded.writes_rd = 1'b1;
         end
         OP_JAL: begin
            decoded.imm       = imm_j;
            decoded.writes_rd = 1'b1;
         end
         OP_JALR, OP_LOAD: decoded.writes_rd = 1'b1;
         OP_BRANCH: decoded.imm = imm_b;
         OP_STORE:  decoded.imm = imm_s;
         OP_IMM, OP_REG: begin
            decoded.writes_rd = 1'b1;
            case (instruction[14:12])
               3'b000:  decoded.alu_op = (alt && instruction[5]) ? ALU_SUB : ALU_ADD;
               3'b001:  decoded.alu_op = ALU_SLL;
               3'b010:  decoded.alu_op = ALU_SLT;
               3'b011:  decoded.alu_op = ALU_SLTU;
               3'b100:  decoded.alu_op = ALU_XOR;
               3'b101:  decoded.alu_op = alt ? ALU_SRA : ALU_SRL;
               3'b110:  decoded.alu_op = ALU_OR;
               default: decoded.alu_op = ALU_AND;
            endcase
         end
         OP_FENCE, OP_SYSTEM: decoded.writes_rd = 1'b0;
         default: decoded.is_illegal = 1'b1; // retires as a no-op.
      endcase
   end

endmodule

// ==== logic/execute.sv ====
`timescale 1ns/100ps

module execute
   import rv32_isa_pkg::*;
   import rv32_core_pkg::*;
(
   input  logic        clock,
   input  logic        rst_n,
   input  logic        exec,
   input  logic        load_done,
   input  decoded_t    decoded,
   input  logic [31:0] instruction_pc,
   input  logic [31:0] read_value,
   output pc_update_t  update,
   output logic        load_request,
   output logic [31:0] load_address,
   output store_t      store,
   output logic        halt_request
);

   logic [31:0] regs [1:31];
   logic [31:0] rs1_value;
   logic [31:0] rs2_value;
   logic [31:0] operand_b;
   logic [31:0] alu_result;
   logic [31:0] result;
   logic [31:0] sum_address;
   logic        branch_taken;
   logic        write_enable;

   // x0 reads as zero.
   assign rs1_value   = (decoded.rs1 == 5'd0) ? 32'd0 : regs[decoded.rs1];
   assign rs2_value   = (decoded.rs2 == 5'd0) ? 32'd0 : regs[decoded.rs2];
   assign operand_b   = (decoded.opcode == OP_REG) ? rs2_value : decoded.imm;
   assign sum_address = rs1_value + decoded.imm;

   always_comb begin
      case (decoded.alu_op)
         ALU_SUB:  alu_result = rs1_value - operand_b;
         ALU_SLL:  alu_result = rs1_value << operand_b[4:0];
         ALU_SLT:  alu_result = {31'd0, $signed(rs1_value) < $signed(operand_b)};
         ALU_SLTU: alu_result = {31'd0, rs1_value < operand_b};
         ALU_XOR:  alu_result = rs1_value ^ operand_b;
         ALU_SRL:  alu_result = rs1_value >> operand_b[4:0];
         ALU_SRA:  alu_result = $signed(rs1_value) >>> operand_b[4:0];
         ALU_OR:   alu_result = rs1_value | operand_b;
         ALU_AND:  alu_result = rs1_value & operand_b;
         default:  alu_result = rs1_value + operand_b;
      endcase
   end

   always_comb begin
      case (branch_f3_e'(decoded.funct3))
         F3_BEQ:  branch_taken = (rs1_value == rs2_value);
         F3_BNE:  branch_taken = (rs1_value != rs2_value);
         F3_BLT:  branch_taken = ($signed(rs1_value) < $signed(rs2_value));
         F3_BGE:  branch_taken = ($signed(rs1_value) >= $signed(rs2_value));
         F3_BLTU: branch_taken = (rs1_value < rs2_value);
         F3_BGEU: branch_taken = (rs1_value >= rs2_value);
         default: branch_taken = 1'b0;
      endcase
   end

   always_comb begin
      case (decoded.opcode)
         OP_LUI:          result = decoded.imm;
         OP_AUIPC:        result = instruction_pc + decoded.imm;
         OP_JAL, OP_JALR: result = instruction_pc + 32'd4; // link value.
         default:         result = alu_result;
      endcase
   end

   always_comb begin
      update.take   = 1'b0;
      update.target = instruction_pc + decoded.imm;
      if (exec && !decoded.is_illegal) begin
         case (decoded.opcode)
            OP_JAL:    update.take = 1'b1;
            OP_JALR: begin
               update.take   = 1'b1;
               update.target = {sum_address[31:1], 1'b0};
            end
            OP_BRANCH: update.take = branch_taken;
            default:   update.take = 1'b0;
         endcase
      end
   end

   assign load_request  = exec && (decoded.opcode == OP_LOAD);
   assign load_address  = sum_address;
   assign store.valid   = exec && (decoded.opcode == OP_STORE);
   assign store.address = sum_address;
   assign store.value   = rs2_value;
   assign halt_request  = exec && (decoded.opcode == OP_SYSTEM);

   // LW writes back one cycle late, in the load cycle.
   assign write_enable = decoded.writes_rd && !decoded.is_illegal && (decoded.rd != 5'd0) &&
                         ((exec && decoded.opcode != OP_LOAD) || load_done);

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= 32'd0;
         end
      end else if (write_enable) begin
         regs[decoded.rd] <= load_done ? read_value : result;
      end
   end

endmodule

// ==== logic/core_top.sv ====
`timescale 1ns/100ps

module core_top
   import rv32_isa_pkg::*;
   import rv32_core_pkg::*;
(
   input  logic        clock,
   input  logic        rst_n,
   input  logic        run,
   input  logic        load_enable,
   input  logic [31:0] load_address,
   input  logic [31:0] load_value,
   output logic        halted,
   output store_t      store
);

   logic        read_enable;
   logic [31:0] read_address;
   logic [31:0] read_value;
   logic [31:0] pc;
   logic [31:0] instruction;
   logic [31:0] instruction_pc;
   logic [31:0] data_address;
   logic        exec;
   logic        load_done;
   logic        retire;
   logic        load_request;
   logic        halt_request;
   pc_update_t  update;
   decoded_t    decoded;
   store_t      core_store;
   store_t      memory_write;

   // preload port owns the write side until run.
   always_comb begin
      if (run) begin
         memory_write = core_store;
      end else begin
         memory_write.valid   = load_enable;
         memory_write.address = load_address;
         memory_write.value   = load_value;
      end
   end

   assign store = core_store;

   memory memory_0 (
      .clock(clock),
      .read_enable(read_enable),
      .read_address(read_address),
      .read_value(read_value),
      .write(memory_write)
   );

   program_counter program_counter_0 (
      .clock(clock),
      .rst_n(rst_n),
      .retire(retire),
      .update(update),
      .pc(pc)
   );

   fetch fetch_0 (
      .clock(clock),
      .rst_n(rst_n),
      .run(run),
      .pc(pc),
      .load_request(load_request),
      .load_address(data_address),
      .halt_request(halt_request),
      .read_enable(read_enable),
      .read_address(read_address),
      .read_value(read_value),
      .instruction(instruction),
      .instruction_pc(instruction_pc),
      .exec(exec),
      .load_done(load_done),
      .retire(retire),
      .halted(halted)
   );

   decode decode_0 (
      .instruction(instruction),
      .decoded(decoded)
   );

   execute execute_0 (
      .clock(clock),
      .rst_n(rst_n),
      .exec(exec),
      .load_done(load_done),
      .decoded(decoded),
      .instruction_pc(instruction_pc),
      .read_value(read_value),
      .update(update),
      .load_request(load_request),
      .load_address(data_address),
      .store(core_store),
      .halt_request(halt_request)
   );

endmodule

// ==== sim/tb_rv32_tests.svh ====
// rv32i reference results.
function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] x,
                                          logic [31:0] y);
   logic [31:0] r;
   case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = {31'd0, $signed(x) < $signed(y)};
      3'd3: r = {31'd0, x < y};
      3'd4: r = x ^ y;
      3'd5: begin
         if (alt) r = $signed(x) >>> y[4:0];
         else r = x >> y[4:0];
      end
      3'd6: r = x | y;
      default: r = x & y;
   endcase
   return r;
endfunction

function automatic logic branch_outcome(logic [2:0] f3, logic [31:0] x, logic [31:0] y);
   case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      default: return x >= y;
   endcase
endfunction

task automatic alu_test();
   logic [2:0]  f3_list [10];
   logic [9:0]  alt_list;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] rnd;
   logic [11:0] imm12;
   f3_list  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
   alt_list = 10'b0010000010; // sub and sra.
   a = $random(seed) | 32'h8000_0000; // signed and unsigned compares disagree.
   b = $random(seed) & 32'h7fff_ffff;
   new_program();
   put_constant(5'd1, a);
   put_constant(5'd2, b);
   for (int k = 0; k < 10; k++) begin
      emit(r_type(alt_list[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, f3_list[k], 5'd3));
      emit(store_word(5'd3, 4 * k));
      expect_store(4 * k, alu_model(f3_list[k], alt_list[k], a, b));
      if (k != 1) begin
         rnd   = $random(seed);
         imm12 = (f3_list[k] == 3'd1 || f3_list[k] == 3'd5) ?
                 {1'b0, alt_list[k], 5'd0, rnd[4:0]} : rnd[11:0];
         emit(i_type(imm12, 5'd1, f3_list[k], 5'd4, OPC_IMM));
         emit(store_word(5'd4, 64 + 4 * k));
         expect_store(64 + 4 * k, alu_model(f3_list[k], alt_list[k], a,
                                            {{20{imm12[11]}}, imm12}));
      end
   end
   emit(ECALL);
   run_test("alu");
endtask

task automatic upper_test();
   logic [31:0] u1;
   logic [31:0] u2;
   logic [31:0] pc;
   u1 = $random(seed);
   u2 = $random(seed);
   new_program();
   emit(u_type(u1[19:0], 5'd5, OPC_LUI));
   emit(store_word(5'd5, 0));
   expect_store(0, {u1[19:0], 12'd0});
   pc = 32'(4 * program_words.size());
   emit(u_type(u2[19:0], 5'd6, OPC_AUIPC));
   emit(store_word(5'd6, 4));
   expect_store(4, pc + {u2[19:0], 12'd0});
   emit(ECALL);
   run_test("upper");
endtask

task automatic branch_test();
   logic [31:0] vals [4];
   int          first [4];
   int          second [4];
   logic [2:0]  f3;
   int          slot;
   vals[0] = $random(seed);
   vals[1] = vals[0] ^ 32'h1;
   vals[2] = $random(seed) | 32'h8000_0000;
   vals[3] = $random(seed) & 32'h7fff_ffff;
   first  = '{0, 0, 2, 3};
   second = '{0, 1, 3, 2};
   new_program();
   for (int i = 0; i < 4; i++) put_constant(5'(10 + i), vals[i]);
   emit(i_type(12'h111, 5'd0, 3'd0, 5'd7, OPC_IMM)); // fall-through marker.
   emit(i_type(12'h222, 5'd0, 3'd0, 5'd8, OPC_IMM)); // taken marker.
   slot = 0;
   for (int f = 0; f < 6; f++) begin
      f3 = 3'(f < 2 ? f : f + 2);
      for (int p = 0; p < 4; p++) begin
         emit(b_type(13'd12, 5'(10 + second[p]), 5'(10 + first[p]), f3));
         emit(store_word(5'd7, 8 * slot));
         emit(j_type(21'd8, 5'd0));
         emit(store_word(5'd8, 8 * slot + 4));
         if (branch_outcome(f3, vals[first[p]], vals[second[p]]))
            expect_store(8 * slot + 4, 32'h222);
         else
            expect_store(8 * slot, 32'h111);
         slot++;
      end
   end
   emit(ECALL);
   run_test("branch");
endtask

task automatic jump_test();
   logic [31:0] pc;
   new_program();
   pc = 32'(4 * program_words.size());
   emit(j_type(21'd12, 5'd9));
   emit(store_word(5'd31, 12'h100)); // skipped by jal.
   emit(store_word(5'd31, 12'h100));
   emit(store_word(5'd9, 0));
   expect_store(0, pc + 32'd4);
   pc = 32'(4 * program_words.size());
   put_constant(5'd10, pc + 32'd13); // plus imm 4 gives an odd target.
   emit(i_type(12'd4, 5'd10, 3'd0, 5'd11, OPC_JALR));
   emit(store_word(5'd31, 12'h100));
   emit(u_type(20'd0, 5'd12, OPC_AUIPC)); // reads back the landing pc.
   emit(store_word(5'd12, 8));
   emit(store_word(5'd11, 4));
   expect_store(8, (pc + 32'd17) & ~32'd1);
   expect_store(4, pc + 32'd12);
   emit(ECALL);
   run_test("jump");
endtask

task automatic memory_test();
   logic [31:0] v;
   v = $random(seed);
   new_program();
   put_constant(5'd12, v);
   emit(store_word(5'd12, 32));
   expect_store(32, v);
   emit(i_type(12'd32, 5'd31, 3'd2, 5'd13, OPC_LOAD));
   emit(store_word(5'd13, 36));
   expect_store(36, v);
   emit(i_type(12'd0, 5'd12, 3'd0, 5'd0, OPC_IMM));
   emit(i_type(12'd32, 5'd31, 3'd2, 5'd0, OPC_LOAD));
   emit(store_word(5'd0, 40));
   expect_store(40, 32'd0);
   emit(FENCE);
   emit(store_word(5'd12, 44));
   expect_store(44, v);
   emit(store_word(5'd13, 48));
   expect_store(48, v);
   emit(ECALL);
   run_test("memory");
endtask

task automatic halt_test();
   logic [31:0] w;
   w = $random(seed);
   new_program();
   put_constant(5'd14, w);
   emit(store_word(5'd14, 64));
   expect_store(64, w);
   emit(ECALL);
   repeat (3) emit(store_word(5'd14, 68)); // must never run.
   run_test("halt");
endtask

// ==== sim/tb_rv32.sv ====
`timescale 1ns/100ps

module tb_rv32
   import rv32_core_pkg::*;
();

   localparam logic [31:0] ECALL = 32'h0000_0073;
   localparam logic [31:0] FENCE = 32'h0ff0_000f;
   localparam logic [6:0]  OPC_LUI   = 7'b0110111;
   localparam logic [6:0]  OPC_AUIPC = 7'b0010111;
   localparam logic [6:0]  OPC_IMM   = 7'b0010011;
   localparam logic [6:0]  OPC_LOAD  = 7'b0000011;
   localparam logic [6:0]  OPC_JALR  = 7'b1100111;
   // 45 + 7 + 109 + 14 + 14 + 9 words over the six programs.
   localparam int PROGRAM_WORDS  = 198;
   localparam int TIMEOUT_CYCLES = 3 * PROGRAM_WORDS + 2000;

   logic        clock = 1'b0;
   logic        rst_n;
   logic        run;
   logic        load_enable;
   logic [31:0] load_address;
   logic [31:0] load_value;
   logic        halted;
   store_t      store;
   integer      seed = 32'h69d6_d194;
   int          cycles = 0;
   logic [31:0] program_words [$];
   store_t      expected [$];

   always #4 clock = ~clock;

   core_top dut_i (
      .clock(clock),
      .rst_n(rst_n),
      .run(run),
      .load_enable(load_enable),
      .load_address(load_address),
      .load_value(load_value),
      .halted(halted),
      .store(store)
   );

   function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw only.
   endfunction

   function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // sw to the data area based at x31.
   function automatic logic [31:0] store_word(logic [4:0] rs2, int offset);
      return s_type(offset[11:0], rs2, 5'd31);
   endfunction

   task automatic emit(logic [31:0] word);
      program_words.push_back(word);
   endtask

   // lui plus addi with the upper part rounded for the sign of the low 12 bits.
   task automatic put_constant(logic [4:0] rd, logic [31:0] value);
      logic [31:0] upper;
      upper = value + 32'h800;
      emit(u_type(upper[31:12], rd, OPC_LUI));
      emit(i_type(value[11:0], rd, 3'd0, rd, OPC_IMM));
   endtask

   task automatic expect_store(int offset, logic [31:0] value);
      store_t want;
      want.valid   = 1'b1;
      want.address = 32'h800 + 32'(offset);
      want.value   = value;
      expected.push_back(want);
   endtask

   task automatic new_program();
      program_words.delete();
      expected.delete();
      put_constant(5'd31, 32'h800);
   endtask

   task automatic report_error(string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(string test, logic [31:0] want, logic [31:0] got);
      assert (got === want) else
         report_error($sformatf("Fail %s: expected %h, actual %h", test, want, got));
   endtask

   task automatic check_store(string test);
      store_t want;
      assert (expected.size() != 0) else
         report_error($sformatf("test %s: unexpected extra store to %h", test, store.address));
      want = expected.pop_front();
      check_value({test, " address"}, want.address, store.address);
      check_value({test, " value"}, want.value, store.value);
   endtask

   task automatic apply_reset();
      @(posedge clock);
      #1 rst_n = 1'b0;
      run = 1'b0;
      repeat (16) @(posedge clock);
      #1 rst_n = 1'b1;
      @(negedge clock);
      assert (!halted && !store.valid && !dut_i.read_enable) else
         report_error("core outputs are not idle after reset");
   endtask

   task automatic load_program();
      foreach (program_words[i]) begin
         @(posedge clock);
         #1 load_enable = 1'b1;
         load_address = 32'(i) * 4;
         load_value   = program_words[i];
      end
      @(posedge clock);
      #1 load_enable = 1'b0;
   endtask

   task automatic run_test(string test);
      int budget;
      apply_reset();
      load_program();
      run = 1'b1;
      budget = 3 * program_words.size() + 16;
      while (!halted && budget > 0) begin
         @(negedge clock);
         if (store.valid) check_store(test);
         budget--;
      end
      assert (halted) else report_error($sformatf("test %s: core did not halt", test));
      assert (expected.size() == 0) else
         report_error($sformatf("test %s: %0d stores never appeared", test, expected.size()));
      // halt is sticky and nothing past ecall runs.
      repeat (8) begin
         @(negedge clock);
         assert (!store.valid) else
            report_error($sformatf("test %s: store pulse after halt", test));
         assert (halted) else report_error($sformatf("test %s: halted dropped", test));
      end
      @(posedge clock);
      #1 run = 1'b0;
   endtask

   `include "tb_rv32_tests.svh"

   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         report_error($sformatf("timeout after %0d cycles", cycles));
      end
   end

   initial begin
      rst_n        = 1'b0;
      run          = 1'b0;
      load_enable  = 1'b0;
      load_address = 32'd0;
      load_value   = 32'd0;
      alu_test();
      upper_test();
      branch_test();
      jump_test();
      memory_test();
      halt_test();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+logic
+incdir+sim
logic/rv32_isa_pkg.sv
logic/rv32_core_pkg.sv
logic/memory.sv
logic/program_counter.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/core_top.sv
sim/tb_rv32.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_rv32 \
   --Mdir obj_dir -o tb_rv32

./obj_dir/tb_rv32 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
